//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --assert --timing -Wno-fatal
TOP       = tb_matrix_inverter
FILELIST  = matrix_inverter.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "Testbench passed" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- elimination_ctrl.sv
`timescale 1ns/1ns

module elimination_ctrl #(
	parameter int matrix_dim = 5,
	localparam int idx_w = $clog2(matrix_dim)
) (
	input logic clk,
	input logic reset,
	input logic start,
	input inverter_pkg::element_t [2*matrix_dim-1:0] pivot_row,
	output logic [idx_w-1:0] pivot_idx,
	output logic [idx_w-1:0] target_idx,
	output logic [idx_w-1:0] col,
	output logic issue,
	output logic init,
	output logic busy,
	output logic done,
	output logic singular
);

	typedef enum logic [2:0] {
		st_idle,
		st_init,
		st_check,
		st_issue,
		st_drain,
		st_finish
	} state_t;

	state_t state;
	logic pivot_zero;
	logic [idx_w-1:0] last_target;
	logic [idx_w-1:0] next_target;

	assign col = pivot_idx;
	assign init = (state == st_init);
	assign pivot_zero = (pivot_row[pivot_idx] == '0);

	// the check cycle already issues the first target.
	assign issue = (state == st_issue) || ((state == st_check) && !pivot_zero);

	assign last_target = (pivot_idx == idx_w'(matrix_dim - 1)) ?
		idx_w'(matrix_dim - 2) : idx_w'(matrix_dim - 1);

	// skip over the pivot row.
	assign next_target = (target_idx + idx_w'(1) == pivot_idx) ?
		target_idx + idx_w'(2) : target_idx + idx_w'(1);

	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			state <= st_idle;
			pivot_idx <= '0;
			target_idx <= '0;
			busy <= 1'b0;
			done <= 1'b0;
			singular <= 1'b0;
		end
		else
		begin
			case (state)
				st_idle, st_finish:
				begin
					if (start)
					begin
						state <= st_init;
						pivot_idx <= '0;
						target_idx <= idx_w'(1);
						busy <= 1'b1;
						done <= 1'b0;
						singular <= 1'b0;
					end
				end
				st_init:
					state <= st_check;
				st_check:
				begin
					if (pivot_zero)
					begin
						state <= st_finish;
						busy <= 1'b0;
						done <= 1'b1;
						singular <= 1'b1;
					end
					else if (target_idx == last_target)
						state <= st_drain;
					else
					begin
						target_idx <= next_target;
						state <= st_issue;
					end
				end
				st_issue:
				begin
					if (target_idx == last_target)
						state <= st_drain;
					else
						target_idx <= next_target;
				end
				st_drain:
				begin
					if (pivot_idx == idx_w'(matrix_dim - 1))
					begin
						state <= st_finish;
						busy <= 1'b0;
						done <= 1'b1;
					end
					else
					begin
						// next pivot is never row 0.
						pivot_idx <= pivot_idx + idx_w'(1);
						target_idx <= '0;
						state <= st_check;
					end
				end
				default:
					state <= st_idle;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (!reset)
		issue |-> (target_idx != pivot_idx));

endmodule

//--- inverter_golden.mem
3
0
00000001 00000002 00000000 00000001 00000003
00000000 00000001 00000003 00000000 00000002
00000000 00000000 00000001 00000002 00000001
00000000 00000000 00000000 00000001 00000004
00000000 00000000 00000000 00000000 00000001
00000001 fffffffe 00000006 fffffff3 0000002f
00000000 00000001 fffffffd 00000006 ffffffe9
00000000 00000000 00000001 fffffffe 00000007
00000000 00000000 00000000 00000001 fffffffc
00000000 00000000 00000000 00000000 00000001
00000001 00000001 00000001 00000001 00000001
0
00000001 00000000 00000000 00000000 00000000
00000003 00000002 00000000 00000000 00000000
00000001 00000001 00000001 00000000 00000000
00000002 00000000 00000001 ffffffff 00000000
00000000 00000001 00000002 00000001 00000001
00000100 00000000 00000000 00000000 00000000
fffffe80 00000080 00000000 00000000 00000000
00000040 ffffffc0 00000080 00000000 00000000
000000a0 ffffffe0 00000040 ffffffc0 00000000
00000020 fffffff0 00000030 fffffff0 fffffff0
00000100 00000100 00000080 00000040 fffffff0
1
00000001 00000002 00000000 00000001 00000001
00000002 00000004 00000000 00000002 00000002
00000003 00000001 00000001 00000000 00000002
00000000 00000001 00000000 00000001 00000000
00000001 00000000 00000002 00000000 00000001
00000001 00000000 00000000 00000000 00000000
fffffffe 00000001 00000000 00000000 00000000
fffffffd 00000000 00000001 00000000 00000000
00000000 00000000 00000000 00000001 00000000
ffffffff 00000000 00000000 00000000 00000001
00000001 00000000 00000001 00000001 00000000

//--- inverter_pkg.sv
package inverter_pkg;

	// one matrix entry, also one bus data word.
	typedef logic [31:0] element_t;

	// word address on the bus.
	typedef logic [7:0] wb_addr_t;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		wb_addr_t addr;
		element_t wdata;
	} wb_req_t;

	typedef struct packed {
		logic ack;
		element_t rdata;
	} wb_rsp_t;

	// word address map.
	localparam wb_addr_t ctrl_addr = 8'd0;
	localparam wb_addr_t coef_base = 8'd64;
	localparam wb_addr_t aug_base = 8'd128;

	// status word bits.
	localparam int status_busy = 0;
	localparam int status_done = 1;
	localparam int status_singular = 2;

	// control word bits on write.
	localparam int ctrl_start = 0;

endpackage

//--- matrix_inverter.f
inverter_pkg.sv
matrix_store.sv
row_combiner.sv
elimination_ctrl.sv
wb_regs.sv
matrix_inverter.sv
tb_matrix_inverter.sv

//--- matrix_inverter.sv
`timescale 1ns/1ns

module matrix_inverter #(
	parameter int matrix_dim = 5
) (
	input logic clk,
	input logic reset,
	input inverter_pkg::wb_req_t wb_req,
	output inverter_pkg::wb_rsp_t wb_rsp
);

	localparam int idx_w = $clog2(matrix_dim);

	logic start;
	logic busy;
	logic done;
	logic singular;
	logic init;
	logic issue;

	logic elem_we;
	logic elem_bank;
	logic [idx_w-1:0] elem_row;
	logic [idx_w-1:0] elem_col;
	inverter_pkg::element_t elem_wdata;
	inverter_pkg::element_t elem_rdata;

	logic [idx_w-1:0] pivot_idx;
	logic [idx_w-1:0] target_idx;
	logic [idx_w-1:0] col;
	inverter_pkg::element_t [2*matrix_dim-1:0] pivot_row;
	inverter_pkg::element_t [2*matrix_dim-1:0] target_row;

	logic result_valid;
	logic [idx_w-1:0] result_idx;
	inverter_pkg::element_t [2*matrix_dim-1:0] result_row;

	wb_regs #(
		.matrix_dim(matrix_dim)
	) u_wb_regs (
		.clk(clk),
		.reset(reset),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.busy(busy),
		.done(done),
		.singular(singular),
		.start(start),
		.elem_we(elem_we),
		.elem_bank(elem_bank),
		.elem_row(elem_row),
		.elem_col(elem_col),
		.elem_wdata(elem_wdata),
		.elem_rdata(elem_rdata)
	);

	matrix_store #(
		.matrix_dim(matrix_dim)
	) u_matrix_store (
		.clk(clk),
		.reset(reset),
		.init(init),
		.elem_we(elem_we),
		.elem_bank(elem_bank),
		.elem_row(elem_row),
		.elem_col(elem_col),
		.elem_wdata(elem_wdata),
		.elem_rdata(elem_rdata),
		.pivot_idx(pivot_idx),
		.target_idx(target_idx),
		.pivot_row(pivot_row),
		.target_row(target_row),
		.result_valid(result_valid),
		.result_idx(result_idx),
		.result_row(result_row)
	);

	row_combiner #(
		.matrix_dim(matrix_dim)
	) u_row_combiner (
		.clk(clk),
		.reset(reset),
		.issue(issue),
		.col(col),
		.target_idx(target_idx),
		.pivot_row(pivot_row),
		.target_row(target_row),
		.result_valid(result_valid),
		.result_idx(result_idx),
		.result_row(result_row)
	);

	elimination_ctrl #(
		.matrix_dim(matrix_dim)
	) u_elimination_ctrl (
		.clk(clk),
		.reset(reset),
		.start(start),
		.pivot_row(pivot_row),
		.pivot_idx(pivot_idx),
		.target_idx(target_idx),
		.col(col),
		.issue(issue),
		.init(init),
		.busy(busy),
		.done(done),
		.singular(singular)
	);

endmodule

//--- matrix_store.sv
`timescale 1ns/1ns

module matrix_store #(
	parameter int matrix_dim = 5,
	localparam int idx_w = $clog2(matrix_dim)
) (
	input logic clk,
	input logic reset,
	input logic init,
	input logic elem_we,
	input logic elem_bank,
	input logic [idx_w-1:0] elem_row,
	input logic [idx_w-1:0] elem_col,
	input inverter_pkg::element_t elem_wdata,
	output inverter_pkg::element_t elem_rdata,
	input logic [idx_w-1:0] pivot_idx,
	input logic [idx_w-1:0] target_idx,
	output inverter_pkg::element_t [2*matrix_dim-1:0] pivot_row,
	output inverter_pkg::element_t [2*matrix_dim-1:0] target_row,
	input logic result_valid,
	input logic [idx_w-1:0] result_idx,
	input inverter_pkg::element_t [2*matrix_dim-1:0] result_row
);

	// coefficient half in columns 0..N-1, augmented half after it.
	inverter_pkg::element_t [2*matrix_dim-1:0] bank [matrix_dim];
	int elem_pos;

	assign elem_pos = int'(elem_col) + (elem_bank ? matrix_dim : 0);

	assign elem_rdata = bank[elem_row][elem_pos];
	assign pivot_row = bank[pivot_idx];
	assign target_row = bank[target_idx];

	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			for (int r = 0; r < matrix_dim; r++)
				bank[r] <= '0;
		end
		else if (init)
		begin
			// identity into the augmented half only.
			for (int r = 0; r < matrix_dim; r++)
			begin
				for (int c = 0; c < matrix_dim; c++)
					bank[r][matrix_dim + c] <= inverter_pkg::element_t'(r == c);
			end
		end
		else if (result_valid)
		begin
			bank[result_idx] <= result_row;
		end
		else if (elem_we)
		begin
			bank[elem_row][elem_pos] <= elem_wdata;
		end
	end

	// bus writes are held off while the engine owns the rows.
	assert property (@(posedge clk) disable iff (!reset)
		!(elem_we && result_valid));

endmodule

//--- row_combiner.sv
`timescale 1ns/1ns

module row_combiner #(
	parameter int matrix_dim = 5,
	localparam int idx_w = $clog2(matrix_dim)
) (
	input logic clk,
	input logic reset,
	input logic issue,
	input logic [idx_w-1:0] col,
	input logic [idx_w-1:0] target_idx,
	input inverter_pkg::element_t [2*matrix_dim-1:0] pivot_row,
	input inverter_pkg::element_t [2*matrix_dim-1:0] target_row,
	output logic result_valid,
	output logic [idx_w-1:0] result_idx,
	output inverter_pkg::element_t [2*matrix_dim-1:0] result_row
);

	inverter_pkg::element_t x;
	inverter_pkg::element_t y;

	// x is the pivot diagonal, y the target entry under it.
	assign x = pivot_row[col];
	assign y = target_row[col];

	always_ff @(posedge clk)
	begin
		if (!reset)
			result_valid <= 1'b0;
		else
			result_valid <= issue;
	end

	// wraps modulo 2^32.
	always_ff @(posedge clk)
	begin
		if (issue)
		begin
			result_idx <= target_idx;
			for (int j = 0; j < 2*matrix_dim; j++)
				result_row[j] <= x * target_row[j] - y * pivot_row[j];
		end
	end

	assert property (@(posedge clk) disable iff (!reset)
		issue |-> (int'(col) < matrix_dim));

endmodule

//--- tb_matrix_inverter.sv
`timescale 1ns/1ns

module tb_matrix_inverter;

	localparam int matrix_dim = 5;
	localparam int cells = matrix_dim * matrix_dim;
	localparam int reset_cycles = 4;
	localparam int bus_ops = 75;
	localparam int op_cycles = 3;
	localparam int run_cycles = matrix_dim * matrix_dim + 1;
	localparam int poll_cycles = 3 * run_cycles;
	localparam int junk_writes = 3;

	logic clk;
	logic reset;
	inverter_pkg::wb_req_t wb_req;
	inverter_pkg::wb_rsp_t wb_rsp;

	int fd;
	int num_cases;
	integer seed;
	int cycle_count;
	int cycle_limit;

	// current case from the golden file.
	inverter_pkg::element_t exp_singular;
	inverter_pkg::element_t in_rows [cells];
	inverter_pkg::element_t exp_aug [cells];
	inverter_pkg::element_t exp_diag [matrix_dim];

	matrix_inverter #(
		.matrix_dim(matrix_dim)
	) dut (
		.clk(clk),
		.reset(reset),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit)
		begin
			$display("timeout: run still going after %0d clock cycles", cycle_limit);
			$display("Testbench failed");
			$fatal(1, "watchdog expired");
		end
	end

	task automatic check_value(input string name, input inverter_pkg::element_t expected,
		input inverter_pkg::element_t actual);
		assert (actual == expected)
		else
		begin
			$display("[FAIL] t=%0t ns %s expected %h actual %h", $time, name, expected, actual);
			$display("Testbench failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// ack is sampled just after each rising edge.
	task automatic wait_ack;
		do
		begin
			@(posedge clk);
			#1;
		end
		while (!wb_rsp.ack);
	endtask

	task automatic bus_write(input inverter_pkg::wb_addr_t addr, input inverter_pkg::element_t data);
		@(posedge clk);
		#1;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we = 1'b1;
		wb_req.addr = addr;
		wb_req.wdata = data;
		wait_ack();
		@(posedge clk);
		#1;
		wb_req.cyc = 1'b0;
		wb_req.stb = 1'b0;
		wb_req.we = 1'b0;
	endtask

	task automatic bus_read(input inverter_pkg::wb_addr_t addr,
		output inverter_pkg::element_t data);
		@(posedge clk);
		#1;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we = 1'b0;
		wb_req.addr = addr;
		wait_ack();
		data = wb_rsp.rdata;
		@(posedge clk);
		#1;
		wb_req.cyc = 1'b0;
		wb_req.stb = 1'b0;
	endtask

	task automatic read_word(output inverter_pkg::element_t value);
		int got;
		got = $fscanf(fd, "%h", value);
		if (got != 1)
		begin
			$display("golden file ended early or holds a value that is not hex");
			$display("Testbench failed");
			$fatal(1, "bad golden file");
		end
	endtask

	task automatic read_case;
		read_word(exp_singular);
		for (int i = 0; i < cells; i++)
			read_word(in_rows[i]);
		for (int i = 0; i < cells; i++)
			read_word(exp_aug[i]);
		for (int i = 0; i < matrix_dim; i++)
			read_word(exp_diag[i]);
	endtask

	task automatic run_case(input int k);
		inverter_pkg::element_t value;
		inverter_pkg::element_t expected;
		inverter_pkg::wb_addr_t addr;
		int pick;
		int r;
		int c;
		// init reloads the identity into the augmented half.
		for (int i = 0; i < cells; i++)
			bus_write(inverter_pkg::coef_base + inverter_pkg::wb_addr_t'(i), in_rows[i]);
		for (int i = 0; i < cells; i++)
		begin
			bus_read(inverter_pkg::coef_base + inverter_pkg::wb_addr_t'(i), value);
			check_value($sformatf("case %0d coef[%0d] before start", k, i), in_rows[i], value);
		end

		expected = '0;
		expected[inverter_pkg::ctrl_start] = 1'b1;
		bus_write(inverter_pkg::ctrl_addr, expected);

		// junk into the coefficient half while the engine runs.
		if (exp_singular == '0)
		begin
			for (int j = 0; j < junk_writes; j++)
			begin
				pick = $random(seed);
				pick = (pick & 32'h7fffffff) % cells;
				addr = inverter_pkg::coef_base + inverter_pkg::wb_addr_t'(pick);
				bus_write(addr, $random(seed));
			end
			bus_read(inverter_pkg::ctrl_addr, value);
			expected = '0;
			expected[inverter_pkg::status_busy] = 1'b1;
			check_value($sformatf("case %0d status after junk writes", k), expected, value);
		end

		do
			bus_read(inverter_pkg::ctrl_addr, value);
		while (value[inverter_pkg::status_done] == 1'b0);
		expected = '0;
		expected[inverter_pkg::status_done] = 1'b1;
		expected[inverter_pkg::status_singular] = exp_singular[0];
		check_value($sformatf("case %0d status at end", k), expected, value);

		for (int i = 0; i < cells; i++)
		begin
			r = i / matrix_dim;
			c = i % matrix_dim;
			bus_read(inverter_pkg::aug_base + inverter_pkg::wb_addr_t'(i), value);
			check_value($sformatf("case %0d aug[%0d][%0d]", k, r, c), exp_aug[i], value);
		end
		for (int i = 0; i < cells; i++)
		begin
			r = i / matrix_dim;
			c = i % matrix_dim;
			bus_read(inverter_pkg::coef_base + inverter_pkg::wb_addr_t'(i), value);
			if (r == c)
				check_value($sformatf("case %0d coef[%0d][%0d]", k, r, c), exp_diag[r], value);
			else if (exp_singular == '0)
				check_value($sformatf("case %0d coef[%0d][%0d]", k, r, c), '0, value);
		end
		$display("case %0d checked", k);
	endtask

	initial
	begin
		inverter_pkg::element_t value;
		reset = 1'b0;
		wb_req = '0;
		seed = 32'h6f9a;
		cycle_count = 0;
		fd = $fopen("inverter_golden.mem", "r");
		if (fd == 0)
		begin
			$display("could not open inverter_golden.mem");
			$display("Testbench failed");
			$fatal(1, "missing golden file");
		end
		if ($fscanf(fd, "%h", num_cases) != 1)
		begin
			$display("golden file does not start with a case count");
			$display("Testbench failed");
			$fatal(1, "bad golden file");
		end
		cycle_limit = 2 * (reset_cycles +
			num_cases * (bus_ops * op_cycles + run_cycles + poll_cycles));

		repeat (reset_cycles)
			@(posedge clk);
		#1;
		reset = 1'b1;

		bus_read(inverter_pkg::ctrl_addr, value);
		check_value("status after reset", '0, value);

		for (int k = 0; k < num_cases; k++)
		begin
			read_case();
			run_case(k);
		end
		$fclose(fd);
		$display("Testbench passed");
		$finish;
	end

endmodule

//--- wb_regs.sv
`timescale 1ns/1ns

module wb_regs #(
	parameter int matrix_dim = 5,
	localparam int idx_w = $clog2(matrix_dim)
) (
	input logic clk,
	input logic reset,
	input inverter_pkg::wb_req_t wb_req,
	output inverter_pkg::wb_rsp_t wb_rsp,
	input logic busy,
	input logic done,
	input logic singular,
	output logic start,
	output logic elem_we,
	output logic elem_bank,
	output logic [idx_w-1:0] elem_row,
	output logic [idx_w-1:0] elem_col,
	output inverter_pkg::element_t elem_wdata,
	input inverter_pkg::element_t elem_rdata
);

	localparam int cells = matrix_dim * matrix_dim;

	logic ack_q;
	logic req;
	logic is_ctrl;
	logic in_coef;
	logic in_aug;
	inverter_pkg::wb_addr_t offset;
	inverter_pkg::element_t status;
	inverter_pkg::element_t rdata_q;

	// new request with no ack pending.
	assign req = wb_req.cyc && wb_req.stb && !ack_q;

	assign is_ctrl = (wb_req.addr == inverter_pkg::ctrl_addr);
	assign in_coef = (wb_req.addr >= inverter_pkg::coef_base) &&
		(wb_req.addr < inverter_pkg::coef_base + cells);
	assign in_aug = (wb_req.addr >= inverter_pkg::aug_base) &&
		(wb_req.addr < inverter_pkg::aug_base + cells);

	assign offset = wb_req.addr - (in_aug ? inverter_pkg::aug_base : inverter_pkg::coef_base);

	assign elem_bank = in_aug;
	assign elem_row = idx_w'(offset / matrix_dim);
	assign elem_col = idx_w'(offset % matrix_dim);
	assign elem_wdata = wb_req.wdata;

	// matrix writes are dropped while busy.
	assign elem_we = req && wb_req.we && (in_coef || in_aug) && !busy;

	always_comb
	begin
		status = '0;
		status[inverter_pkg::status_busy] = busy;
		status[inverter_pkg::status_done] = done;
		status[inverter_pkg::status_singular] = singular;
	end

	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			ack_q <= 1'b0;
			start <= 1'b0;
		end
		else
		begin
			ack_q <= req;
			start <= req && wb_req.we && is_ctrl &&
				wb_req.wdata[inverter_pkg::ctrl_start] && !busy;
		end
	end

	// unmapped words read as zero.
	always_ff @(posedge clk)
	begin
		if (req)
		begin
			if (is_ctrl)
				rdata_q <= status;
			else if (in_coef || in_aug)
				rdata_q <= elem_rdata;
			else
				rdata_q <= '0;
		end
	end

	assign wb_rsp.ack = ack_q;
	assign wb_rsp.rdata = rdata_q;

	// the master holds its request through the ack cycle.
	assert property (@(posedge clk) disable iff (!reset)
		wb_rsp.ack |-> (wb_req.cyc && wb_req.stb));

endmodule
